// File: hw/alu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module alu (
    input  riscvPkg::wordT    a,
    input  riscvPkg::wordT    b,
    input  riscvPkg::aluCtrlE aluControl,
    output riscvPkg::wordT    result,
    output logic              zero,                // Result is all zeros
    output logic              lessThan             // Signed a < b
);
    import riscvPkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt    = b[SHAMT_W-1:0];              // Low bits only
    assign lessThan = $signed(a) < $signed(b);     // Independent of the operation

    always_comb begin
        case (aluControl)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_SLL:   result = a << shamt;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = wordT'($signed(a) >>> shamt);
            ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lessThan};
            ALU_PASSB: result = b;                 // Upper immediate
            default:   result = a + b;
        endcase
    end

    assign zero = (result == '0);                  // BEQ/BNE flag after subtract

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  riscvPkg::opcodeE op,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,             // Selects SUB and SRA
    ctrlIf.source            ctrl
);
    import riscvPkg::*;

    logic [1:0] aluOp;
    logic       rTypeAlt;                          // SUB or SRA, register form only

    mainDecoder md0 (
        .op    (op),
        .funct3(funct3),
        .ctrl  (ctrl),
        .aluOp (aluOp)
    );

    assign rTypeAlt = (op == OP_REG) && funct7b5;

    always_comb begin
        case (aluOp)
            2'b00: ctrl.aluControl = ALU_ADD;      // Address and jump target
            2'b01: ctrl.aluControl = ALU_SUB;      // Branch compare
            2'b11: ctrl.aluControl = ALU_PASSB;    // LUI
            default: begin
                case (funct3)
                    3'b000:  ctrl.aluControl = rTypeAlt ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.aluControl = ALU_SLL;
                    3'b010:  ctrl.aluControl = ALU_SLT;
                    3'b100:  ctrl.aluControl = ALU_XOR;
                    3'b101:  ctrl.aluControl = rTypeAlt ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl.aluControl = ALU_OR;
                    3'b111:  ctrl.aluControl = ALU_AND;
                    default: ctrl.aluControl = ALU_ADD; // SLTU not supported
                endcase
            end
        endcase
    end

    // Branch condition from funct3, ignored unless branch is set
    always_comb begin
        case (funct3)
            3'b001:  ctrl.branchType = BR_NE;
            3'b100:  ctrl.branchType = BR_LT;
            3'b101:  ctrl.branchType = BR_GE;
            default: ctrl.branchType = BR_EQ;
        endcase
    end

    // Fetched words must always decode to a known ALU operation
    aluCtrlKnown: assert property (@(posedge ctrl.clk) disable iff (ctrl.reset)
        !$isunknown(ctrl.aluControl))
        else $error("controlUnit: aluControl unknown");

endmodule

// File: hw/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Machine word and address width
`define XLEN 32

// Architectural register count
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: hw/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf (
    input logic clk,                               // Only for checkers
    input logic reset
);
    import riscvPkg::*;

    logic      regWrite;
    logic      memWrite;
    logic      aluSrc;                             // Immediate as operand b
    resultSrcE resultSrc;
    immSrcE    immSrc;
    aluCtrlE   aluControl;
    memSizeE   sizeSrc;
    logic      branch;
    logic      jump;
    logic      jalr;
    branchE    branchType;

    modport source (input clk, reset, output regWrite, memWrite, aluSrc, resultSrc, immSrc,
                    aluControl, sizeSrc, branch, jump, jalr, branchType);
    modport sink   (input regWrite, memWrite, aluSrc, resultSrc, immSrc,
                    aluControl, sizeSrc, branch, jump, jalr, branchType);

endinterface

// File: hw/datapath.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module datapath (
    input  logic              clk,
    input  logic              reset,
    input  riscvPkg::wordT    instr,               // Fetched word for pc
    input  riscvPkg::wordT    readData,            // Data word holding dataAddr
    output riscvPkg::wordT    pc,
    output riscvPkg::wordT    dataAddr,
    output riscvPkg::wordT    writeData,
    output logic [3:0]        byteEnable,
    output logic              memWrite,
    output riscvPkg::opcodeE  op,
    output logic [2:0]        funct3,
    output logic              funct7b5,
    ctrlIf.sink               ctrl
);
    import riscvPkg::*;

    wordT pcNext;
    wordT pcPlus4;
    wordT pcTarget;                                // Branch and JAL target
    wordT immExt;
    wordT srcA;
    wordT srcB;
    wordT rs2Data;
    wordT aluResult;
    wordT loadData;
    wordT result;                                  // Write-back value
    logic zero;
    logic lessThan;
    logic branchTaken;

    // Fields for the control unit
    assign op       = opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // Immediate extension
    always_comb begin
        case (ctrl.immSrc)
            IMM_I:  immExt = {{20{instr[31]}}, instr[31:20]};
            IMM_S:  immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:  immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: begin
                if (op == OP_LUI) begin
                    immExt = {instr[31:12], 12'b0};                             // U form
                end else begin
                    immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                end
            end
        endcase
    end

    regFile rf0 (
        .clk        (clk),
        .writeEnable(ctrl.regWrite && !reset),     // No write-back while in reset
        .readAddr1  (instr[19:15]),
        .readAddr2  (instr[24:20]),
        .writeAddr  (instr[11:7]),
        .writeData  (result),
        .readData1  (srcA),
        .readData2  (rs2Data)
    );

    assign srcB = ctrl.aluSrc ? immExt : rs2Data;

    alu alu0 (
        .a         (srcA),
        .b         (srcB),
        .aluControl(ctrl.aluControl),
        .result    (aluResult),
        .zero      (zero),
        .lessThan  (lessThan)
    );

    assign dataAddr = aluResult;
    assign memWrite = ctrl.memWrite && !reset;     // No stores during reset

    loadStoreAlign lsa0 (
        .addrLow   (aluResult[1:0]),
        .size      (ctrl.sizeSrc),
        .storeData (rs2Data),
        .readWord  (readData),
        .memWrite  (memWrite),
        .writeData (writeData),
        .byteEnable(byteEnable),
        .loadData  (loadData)
    );

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: result = loadData;
            RES_PC4: result = pcPlus4;             // Link value
            default: result = aluResult;
        endcase
    end

    // Branch condition on the subtract flags
    always_comb begin
        case (ctrl.branchType)
            BR_EQ:   branchTaken = zero;
            BR_NE:   branchTaken = !zero;
            BR_LT:   branchTaken = lessThan;
            default: branchTaken = !lessThan;      // BGE
        endcase
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt;

    always_comb begin
        if (ctrl.jalr) begin
            pcNext = {aluResult[31:1], 1'b0};      // rs1 + imm, bit 0 cleared
        end else if (ctrl.jump || (ctrl.branch && branchTaken)) begin
            pcNext = pcTarget;
        end else begin
            pcNext = pcPlus4;
        end
    end

endmodule

// File: hw/loadStoreAlign.sv
`timescale 1ns/1ps

module loadStoreAlign (
    input  logic [1:0]        addrLow,             // Byte offset in the word
    input  riscvPkg::memSizeE size,
    input  riscvPkg::wordT    storeData,           // rs2 as read
    input  riscvPkg::wordT    readWord,            // Whole word from memory
    input  logic              memWrite,
    output riscvPkg::wordT    writeData,           // Lane-aligned store data
    output logic [3:0]        byteEnable,
    output riscvPkg::wordT    loadData             // Extended load result
);
    import riscvPkg::*;

    wordT laneWord;                                // Addressed bytes moved to bit 0

    // Store side
    always_comb begin
        case (size)
            SIZE_B: begin
                writeData  = storeData << {addrLow, 3'b000};
                byteEnable = 4'b0001 << addrLow;
            end
            SIZE_H: begin
                writeData  = storeData << {addrLow[1], 4'b0000};
                byteEnable = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                writeData  = storeData;            // Full word
                byteEnable = 4'b1111;
            end
        endcase
        if (!memWrite) begin
            byteEnable = 4'b0000;                  // No lanes outside stores
        end
    end

    // Load side
    assign laneWord = readWord >> {addrLow, 3'b000};

    always_comb begin
        case (size)
            SIZE_B:  loadData = {{24{laneWord[7]}}, laneWord[7:0]};
            SIZE_BU: loadData = {24'b0, laneWord[7:0]};
            SIZE_H:  loadData = {{16{laneWord[15]}}, laneWord[15:0]};
            SIZE_HU: loadData = {16'b0, laneWord[15:0]};
            default: loadData = readWord;
        endcase
    end

    // Halfwords on even bytes, words on word boundaries
    always_comb begin
        if (!$isunknown({size, addrLow})) begin
            alignChk: assert final (
                !(((size == SIZE_H) || (size == SIZE_HU)) && addrLow[0]) &&
                !((size == SIZE_W) && (addrLow != 2'b00)))
                else $error("loadStoreAlign: misaligned access, size %s offset %0d",
                            size.name(), addrLow);
        end
    end

endmodule

// File: hw/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder (
    input  riscvPkg::opcodeE op,                   // Major opcode
    input  logic [2:0]       funct3,               // Size code for loads and stores
    ctrlIf.source            ctrl,                 // Main control fields
    output logic [1:0]       aluOp                 // Coarse ALU class for controlUnit
);
    import riscvPkg::*;

    always_comb begin
        // All inactive unless the opcode says otherwise
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = IMM_I;
        ctrl.resultSrc = RES_ALU;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.jalr      = 1'b0;
        ctrl.sizeSrc   = SIZE_B;
        aluOp          = 2'b00;                    // Add

        case (op)
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_JU;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_PC4;          // Link
                ctrl.jump      = 1'b1;
            end
            OP_JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_I;
                ctrl.aluSrc    = 1'b1;             // rs1 + imm is the target
                ctrl.resultSrc = RES_PC4;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.immSrc    = IMM_B;
                aluOp          = 2'b01;            // Compare by subtract
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = RES_MEM;
                case (funct3)
                    3'b000:  ctrl.sizeSrc = SIZE_B;
                    3'b001:  ctrl.sizeSrc = SIZE_H;
                    3'b010:  ctrl.sizeSrc = SIZE_W;
                    3'b100:  ctrl.sizeSrc = SIZE_BU;
                    3'b101:  ctrl.sizeSrc = SIZE_HU;
                    default: ctrl.sizeSrc = SIZE_B;
                endcase
            end
            OP_STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.immSrc    = IMM_S;
                ctrl.aluSrc    = 1'b1;
                case (funct3)
                    3'b001:  ctrl.sizeSrc = SIZE_H;
                    3'b010:  ctrl.sizeSrc = SIZE_W;
                    default: ctrl.sizeSrc = SIZE_B; // SB and illegal codes
                endcase
            end
            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                aluOp          = 2'b10;            // Decode by funct3
            end
            OP_REG: begin
                ctrl.regWrite  = 1'b1;
                aluOp          = 2'b10;
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = IMM_JU;
                ctrl.aluSrc    = 1'b1;
                aluOp          = 2'b11;            // Pass immediate
            end
            default: begin
                // Unsupported opcode keeps the defaults, a no-op
            end
        endcase
    end

    // A store never writes back, and no write-back instruction touches memory
    noStoreWriteBack: assert property (@(posedge ctrl.clk) disable iff (ctrl.reset)
        !(ctrl.memWrite && ctrl.regWrite))
        else $error("mainDecoder: memWrite and regWrite both high");

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regFile #(
    parameter int ADDR_W = $clog2(`REG_COUNT)
) (
    input  logic                clk,
    input  logic                writeEnable,
    input  logic [ADDR_W-1:0]   readAddr1,         // rs1
    input  logic [ADDR_W-1:0]   readAddr2,         // rs2
    input  logic [ADDR_W-1:0]   writeAddr,         // rd
    input  riscvPkg::wordT      writeData,
    output riscvPkg::wordT      readData1,
    output riscvPkg::wordT      readData2
);

    riscvPkg::wordT regs [`REG_COUNT];             // No reset, contents undefined at start

    always_ff @(posedge clk) begin
        if (writeEnable && (writeAddr != '0)) begin // x0 stays untouched
            regs[writeAddr] <= writeData;
        end
    end

    // x0 reads zero
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: hw/riscvPkg.sv
`include "core_settings.svh"

package riscvPkg;

    typedef logic [`XLEN-1:0] wordT;              // One machine word

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT,
        ALU_PASSB                                  // Operand b straight out, for LUI
    } aluCtrlE;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10                            // Link value
    } resultSrcE;

    typedef enum logic [1:0] {
        IMM_I  = 2'b00,
        IMM_S  = 2'b01,
        IMM_B  = 2'b10,
        IMM_JU = 2'b11                             // J for JAL, U for LUI
    } immSrcE;

    // Same codes as funct3 of loads and stores
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } memSizeE;

    typedef enum logic [1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE
    } branchE;

endpackage

// File: hw/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic           clk,
    input  logic           reset,
    input  riscvPkg::wordT instr,                  // Instruction memory read
    input  riscvPkg::wordT readData,               // Data memory read
    output riscvPkg::wordT pc,
    output riscvPkg::wordT dataAddr,
    output riscvPkg::wordT writeData,
    output logic [3:0]     byteEnable,
    output logic           memWrite
);
    import riscvPkg::*;

    opcodeE     op;
    logic [2:0] funct3;
    logic       funct7b5;

    ctrlIf ctrl0 (
        .clk  (clk),
        .reset(reset)
    );

    controlUnit cu0 (
        .op      (op),
        .funct3  (funct3),
        .funct7b5(funct7b5),
        .ctrl    (ctrl0)
    );

    datapath dp0 (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .byteEnable(byteEnable),
        .memWrite  (memWrite),
        .op        (op),
        .funct3    (funct3),
        .funct7b5  (funct7b5),
        .ctrl      (ctrl0)
    );

endmodule

// File: tests/rvCoreTb.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module rvCoreTb;
    import riscvPkg::*;

    localparam int MEM_WORDS = 256;                // 1 KB each for code and data
    localparam int HALT_WAIT = 2000;               // Cycles allowed after reset

    logic       clk;
    logic       reset;
    wordT       instr;
    wordT       readData;
    wordT       pc;
    wordT       dataAddr;
    wordT       writeData;
    logic [3:0] byteEnable;
    logic       memWrite;

    wordT       imem [MEM_WORDS];
    wordT       dmem [MEM_WORDS];
    wordT       expAddr [$];                       // Expected store trace, in order
    wordT       expData [$];                       // Already masked to the lanes
    logic [3:0] expMask [$];
    wordT       haltPc;                            // Last program word, a self-jump
    int         storeCount;

    rvCore dut0 (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .byteEnable(byteEnable),
        .memWrite  (memWrite)
    );

    // Both memories read asynchronously
    assign instr    = imem[pc[9:2]];
    assign readData = dmem[dataAddr[9:2]];

    always #5 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkMask(input string name, input logic [3:0] expected,
                             input logic [3:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    function automatic wordT laneBits(input logic [3:0] lanes);
        return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    endfunction

    task automatic writeStoreLanes();
        for (int lane = 0; lane < 4; lane++) begin
            if (byteEnable[lane]) begin
                dmem[dataAddr[9:2]][8*lane +: 8] = writeData[8*lane +: 8];
            end
        end
    endtask

    task automatic loadVectors();
        int               fd;
        int               n;
        logic             done;
        logic [7:0]       tag;
        wordT             addr;
        wordT             word;
        wordT             lanes;
        logic [8*200-1:0] restOfLine;
        fd = $fopen("tests/rvCore_vectors.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open tests/rvCore_vectors.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, " %c", tag);       // Record type letter
                if (n != 1) begin
                    done = 1'b1;                   // End of file
                end else begin
                    case (tag)
                        "I": begin
                            n = $fscanf(fd, "%h %h", addr, word);
                            imem[addr[9:2]] = word;
                            haltPc = addr;
                        end
                        "D": begin
                            n = $fscanf(fd, "%h %h", addr, word);
                            dmem[addr[9:2]] = word;
                        end
                        "S": begin
                            n = $fscanf(fd, "%h %h %h", addr, word, lanes);
                            expAddr.push_back(addr);
                            expData.push_back(word);
                            expMask.push_back(lanes[3:0]);
                        end
                        default: begin
                            // Comment line
                        end
                    endcase
                    n = $fgets(restOfLine, fd);    // Drop trailing text
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic waitForHalt();
        int cycles;
        int settled;
        cycles  = 0;
        settled = 0;
        while ((settled < 2) && (cycles < HALT_WAIT)) begin
            @(negedge clk);
            cycles++;
            if (pc === haltPc) begin
                settled++;
            end else begin
                settled = 0;
            end
        end
        if (settled < 2) begin
            abortRun("timeout, pc never settled at the halt address");
        end
    endtask

    // Mid-cycle sampling, all DUT outputs stable
    always @(negedge clk) begin
        if (reset) begin
            checkBit("reset memWrite", 1'b0, memWrite);
            checkWord("reset pc", `RESET_PC, pc);
        end else if (memWrite) begin
            if (expAddr.size() == 0) begin
                abortRun($sformatf("unexpected store at address %h", dataAddr));
            end else begin
                checkWord($sformatf("store %0d address", storeCount), expAddr[0], dataAddr);
                checkWord($sformatf("store %0d data", storeCount), expData[0],
                          writeData & laneBits(byteEnable));
                checkMask($sformatf("store %0d lanes", storeCount), expMask[0], byteEnable);
                writeStoreLanes();
                expAddr.delete(0);
                expData.delete(0);
                expMask.delete(0);
                storeCount++;
            end
        end
        if (!memWrite) begin
            checkMask("idle lanes", 4'b0000, byteEnable); // Lanes only on stores
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        storeCount = 0;
        haltPc     = `RESET_PC;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {i[24:0], 7'b0100011};      // Store opcode tagged with address
            dmem[i] = {16'hD00D ^ i[15:0], i[15:0]};
        end
        repeat (8) @(posedge clk);                 // Fill store sits at the reset PC
        loadVectors();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;                           // Just after the edge
        waitForHalt();
        if (expAddr.size() != 0) begin
            abortRun($sformatf("%0d expected stores never happened", expAddr.size()));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: tests/rvCore_vectors.txt
# I lines give byte address and instruction word, D lines a preloaded data word
# S lines give store byte address, data masked to its lanes, and byte lanes
I 000 12C00093  # addi x1, x0, 300
I 004 F9C00113  # addi x2, x0, -100
I 008 00400393  # addi x7, x0, 4
I 00C 002081B3  # add  x3, x1, x2
I 010 20302023  # sw   x3, 0x200(x0)
I 014 401101B3  # sub  x3, x2, x1
I 018 20302223  # sw   x3, 0x204(x0)
I 01C 0020F1B3  # and  x3, x1, x2
I 020 20302423  # sw   x3, 0x208(x0)
I 024 0020E1B3  # or   x3, x1, x2
I 028 20302623  # sw   x3, 0x20C(x0)
I 02C 0020C1B3  # xor  x3, x1, x2
I 030 20302823  # sw   x3, 0x210(x0)
I 034 001121B3  # slt  x3, x2, x1
I 038 20302A23  # sw   x3, 0x214(x0)
I 03C 007091B3  # sll  x3, x1, x7
I 040 20302C23  # sw   x3, 0x218(x0)
I 044 007151B3  # srl  x3, x2, x7
I 048 20302E23  # sw   x3, 0x21C(x0)
I 04C 407151B3  # sra  x3, x2, x7
I 050 22302023  # sw   x3, 0x220(x0)
I 054 0F017193  # andi x3, x2, 0x0F0
I 058 22302223  # sw   x3, 0x224(x0)
I 05C FF00E193  # ori  x3, x1, -16
I 060 22302423  # sw   x3, 0x228(x0)
I 064 FFF14193  # xori x3, x2, -1
I 068 22302623  # sw   x3, 0x22C(x0)
I 06C F9D12193  # slti x3, x2, -99
I 070 22302823  # sw   x3, 0x230(x0)
I 074 30000183  # lb   x3, 0x300(x0)
I 078 22302A23  # sw   x3, 0x234(x0)
I 07C 30304183  # lbu  x3, 0x303(x0)
I 080 22302C23  # sw   x3, 0x238(x0)
I 084 30201183  # lh   x3, 0x302(x0)
I 088 22302E23  # sw   x3, 0x23C(x0)
I 08C 30005183  # lhu  x3, 0x300(x0)
I 090 24302023  # sw   x3, 0x240(x0)
I 094 30402183  # lw   x3, 0x304(x0)
I 098 24302223  # sw   x3, 0x244(x0)
I 09C 24300423  # sb   x3, 0x248(x0)
I 0A0 243004A3  # sb   x3, 0x249(x0)
I 0A4 24300523  # sb   x3, 0x24A(x0)
I 0A8 243005A3  # sb   x3, 0x24B(x0)
I 0AC 24301623  # sh   x3, 0x24C(x0)
I 0B0 24301723  # sh   x3, 0x24E(x0)
I 0B4 00108463  # beq  x1, x1, +8 taken
I 0B8 24702823  # sw   x7, 0x250(x0) skipped
I 0BC 00109463  # bne  x1, x1, +8 not taken
I 0C0 24702A23  # sw   x7, 0x254(x0)
I 0C4 00114463  # blt  x2, x1, +8 taken
I 0C8 24702C23  # sw   x7, 0x258(x0) skipped
I 0CC 0020C463  # blt  x1, x2, +8 not taken
I 0D0 24102E23  # sw   x1, 0x25C(x0)
I 0D4 0020D463  # bge  x1, x2, +8 taken
I 0D8 26702023  # sw   x7, 0x260(x0) skipped
I 0DC 00115463  # bge  x2, x1, +8 not taken
I 0E0 26202223  # sw   x2, 0x264(x0)
I 0E4 00209463  # bne  x1, x2, +8 taken
I 0E8 26702423  # sw   x7, 0x268(x0) skipped
I 0EC 00208463  # beq  x1, x2, +8 not taken
I 0F0 26702623  # sw   x7, 0x26C(x0)
I 0F4 008002EF  # jal  x5, +8
I 0F8 26702823  # sw   x7, 0x270(x0) skipped
I 0FC 26502A23  # sw   x5, 0x274(x0)
I 100 10900313  # addi x6, x0, 0x109
I 104 00430467  # jalr x8, 4(x6) to 0x10C
I 108 26702C23  # sw   x7, 0x278(x0) skipped
I 10C 26802E23  # sw   x8, 0x27C(x0)
I 110 ABCDE4B7  # lui  x9, 0xABCDE
I 114 28902023  # sw   x9, 0x280(x0)
I 118 12345497  # auipc x9, 0x12345 unsupported
I 11C 28902223  # sw   x9, 0x284(x0)
I 120 0000006F  # jal  x0, 0 halt
D 300 80F17F85
D 304 12345678
S 200 000000C8 F
S 204 FFFFFE70 F
S 208 0000010C F
S 20C FFFFFFBC F
S 210 FFFFFEB0 F
S 214 00000001 F
S 218 000012C0 F
S 21C 0FFFFFF9 F
S 220 FFFFFFF9 F
S 224 00000090 F
S 228 FFFFFFFC F
S 22C 00000063 F
S 230 00000001 F
S 234 FFFFFF85 F
S 238 00000080 F
S 23C FFFF80F1 F
S 240 00007F85 F
S 244 12345678 F
S 248 00000078 1
S 249 00007800 2
S 24A 00780000 4
S 24B 78000000 8
S 24C 00005678 3
S 24E 56780000 C
S 254 00000004 F
S 25C 0000012C F
S 264 FFFFFF9C F
S 26C 00000004 F
S 274 000000F8 F
S 27C 00000108 F
S 280 ABCDE000 F
S 284 ABCDE000 F

// File: verilog.f
+incdir+hw
hw/riscvPkg.sv
hw/ctrlIf.sv
hw/mainDecoder.sv
hw/controlUnit.sv
hw/regFile.sv
hw/alu.sv
hw/loadStoreAlign.sv
hw/datapath.sv
hw/rvCore.sv
tests/rvCoreTb.sv
